// File: hdl/pkt_check_pkg.sv
`default_nettype none

package pkt_check_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// Memory word address and data
	localparam int ADDR_W = 14;
	localparam int WORD_W = 32;

	// One payload byte
	localparam int BYTE_W = 8;

	// Byte count and packet type share this width
	localparam int CNT_W = 4;

	// Hamming code over the 8 protected header bits
	localparam int ECC_W = 4;

	////////////////////////////////////////////////////////////////////////////
	// Header word layout
	////////////////////////////////////////////////////////////////////////////

	localparam int ECC_LSB     = 0;
	localparam int CNT_LSB     = 4;
	localparam int TYPE_LSB    = 8;
	localparam int ECC_MSB_POS = 12;
	// Bits 15..13 hold the SOP field, not used here

	// CRC-8, zero init, MSB first, no final XOR
	localparam logic [BYTE_W-1:0] CRC_POLY = 8'h07;

	// Byte buffer between reader and CRC stage
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

	// Tag carried with every buffered byte
	typedef enum logic [0:0] {
		KIND_DATA,
		KIND_CRC
	} byte_kind_t;

	// Header reader FSM
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_HEADER,
		RD_DATA,
		RD_RELEASE
	} rd_state_t;

endpackage

`default_nettype wire

// File: hdl/hdr_reader.sv
`default_nettype none

module hdr_reader (
	input  logic                               clk,
	input  logic                               reset,
	// Request from the top level
	input  logic                               req_i,
	input  logic [pkt_check_pkg::ADDR_W-1:0]   hdr_addr_i,
	// Packet memory read port, one cycle latency
	output logic                               mem_rd_o,
	output logic [pkt_check_pkg::ADDR_W-1:0]   mem_addr_o,
	input  logic [pkt_check_pkg::WORD_W-1:0]   mem_data_i,
	// Push side of the byte FIFO
	output logic                               push_o,
	output logic [pkt_check_pkg::BYTE_W-1:0]   push_data_o,
	output pkt_check_pkg::byte_kind_t          push_kind_o,
	input  logic                               full_i,
	// Header results, held until the next header is decoded
	output logic                               ecc_corr_o,
	output logic                               ecc_uncorr_o,
	output logic [pkt_check_pkg::CNT_W-1:0]    pkt_type_o,
	output logic [pkt_check_pkg::CNT_W-1:0]    byte_cnt_o
);
	import pkt_check_pkg::*;

	rd_state_t           state_q;
	// High in the cycle the read data is on mem_data_i
	logic                wait_q;
	logic [ADDR_W-1:0]   addr_q;
	// Data bytes still to be pushed before the CRC byte
	logic [CNT_W-1:0]    rem_q;
	logic                rd_issue;
	logic [2*CNT_W-1:0]  hdr_d;
	logic [ECC_W-1:0]    syndrome;
	logic                par_diff;

	// Code bits over {type, count}
	function automatic logic [ECC_W-1:0] ecc_code(input logic [2*CNT_W-1:0] d);
		logic [ECC_W-1:0] c;
		c[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6];
		c[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
		c[2] = d[1] ^ d[2] ^ d[3] ^ d[7];
		c[3] = d[4] ^ d[5] ^ d[6] ^ d[7];
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Header decode
	////////////////////////////////////////////////////////////////////////////

	// Type is the high half, count the low half
	assign hdr_d    = {mem_data_i[TYPE_LSB +: CNT_W], mem_data_i[CNT_LSB +: CNT_W]};
	assign syndrome = mem_data_i[ECC_LSB +: ECC_W] ^ ecc_code(hdr_d);
	// Stored MSB against overall parity of the protected bits
	assign par_diff = mem_data_i[ECC_MSB_POS] ^ (^hdr_d);

	////////////////////////////////////////////////////////////////////////////
	// Memory port and push strobes
	////////////////////////////////////////////////////////////////////////////

	// One read in flight at most, and only with room in the FIFO
	assign rd_issue   = ((state_q == RD_HEADER) || (state_q == RD_DATA)) && !wait_q && !full_i;
	assign mem_rd_o   = rd_issue;
	assign mem_addr_o = addr_q;

	// Low byte of each word after the header goes to the FIFO
	assign push_o      = (state_q == RD_DATA) && wait_q;
	assign push_data_o = mem_data_i[BYTE_W-1:0];
	// Last word of the packet carries the stored CRC
	assign push_kind_o = (rem_q == '0) ? KIND_CRC : KIND_DATA;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q      <= RD_IDLE;
			wait_q       <= 1'b0;
			rem_q        <= '0;
			ecc_corr_o   <= 1'b0;
			ecc_uncorr_o <= 1'b0;
		end else begin
			if (rd_issue)
				wait_q <= 1'b1;
			case (state_q)
				RD_IDLE: begin
					if (req_i)
						state_q <= RD_HEADER;
				end
				RD_HEADER: begin
					if (wait_q) begin
						wait_q       <= 1'b0;
						rem_q        <= mem_data_i[CNT_LSB +: CNT_W];
						// Nonzero syndrome, parity decides single or double
						ecc_corr_o   <= (syndrome != '0) && par_diff;
						ecc_uncorr_o <= (syndrome != '0) && !par_diff;
						state_q      <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (wait_q) begin
						wait_q <= 1'b0;
						if (rem_q == '0)
							state_q <= RD_RELEASE;
						else
							rem_q <= rem_q - 1'b1;
					end
				end
				RD_RELEASE: begin
					// Hold until the requester drops req
					if (!req_i)
						state_q <= RD_IDLE;
				end
				default: state_q <= RD_IDLE;
			endcase
		end
	end

	// Word address walks from the header through the CRC word
	always_ff @(posedge clk) begin
		if ((state_q == RD_IDLE) && req_i)
			addr_q <= hdr_addr_i;
		else if (wait_q)
			addr_q <= addr_q + 1'b1;
	end

	// Header fields
	always_ff @(posedge clk) begin
		if ((state_q == RD_HEADER) && wait_q) begin
			pkt_type_o <= mem_data_i[TYPE_LSB +: CNT_W];
			byte_cnt_o <= mem_data_i[CNT_LSB +: CNT_W];
		end
	end

endmodule

`default_nettype wire

// File: hdl/byte_fifo.sv
`default_nettype none

module byte_fifo (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              push_i,
	input  logic                              pop_i,
	input  logic [pkt_check_pkg::BYTE_W-1:0]  push_data_i,
	input  pkt_check_pkg::byte_kind_t         push_kind_i,
	output logic [pkt_check_pkg::BYTE_W-1:0]  pop_data_o,
	output pkt_check_pkg::byte_kind_t         pop_kind_o,
	output logic                              full_o,
	output logic                              empty_o
);
	import pkt_check_pkg::*;

	// Storage
	logic [BYTE_W-1:0]     data_mem [FIFO_DEPTH];
	byte_kind_t            kind_mem [FIFO_DEPTH];

	// Pointers wrap naturally, depth is a power of two
	logic [FIFO_PTR_W-1:0] wr_ptr_q;
	logic [FIFO_PTR_W-1:0] rd_ptr_q;
	logic [FIFO_CNT_W-1:0] count_q;
	logic                  do_push;
	logic                  do_pop;

	assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
	assign empty_o = (count_q == '0);

	// Push when full and pop when empty are dropped
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	// Show-ahead read of the oldest entry
	assign pop_data_o = data_mem[rd_ptr_q];
	assign pop_kind_o = kind_mem[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (do_push) begin
			data_mem[wr_ptr_q] <= push_data_i;
			kind_mem[wr_ptr_q] <= push_kind_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			// Occupancy only moves on a lone push or a lone pop
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/crc_checker.sv
`default_nettype none

module crc_checker (
	input  logic                              clk,
	input  logic                              reset,
	// Top level request, only used to release ack
	input  logic                              req_i,
	// Pop side of the byte FIFO
	output logic                              pop_o,
	input  logic [pkt_check_pkg::BYTE_W-1:0]  pop_data_i,
	input  pkt_check_pkg::byte_kind_t         pop_kind_i,
	input  logic                              empty_i,
	// Results toward the requester
	output logic                              ack_o,
	output logic                              crc_err_o
);
	import pkt_check_pkg::*;

	// Running CRC over the data bytes of the current packet
	logic [BYTE_W-1:0] crc_q;
	logic [BYTE_W-1:0] crc_upd;

	////////////////////////////////////////////////////////////////////////////
	// CRC-8 step
	////////////////////////////////////////////////////////////////////////////

	// One byte, MSB first, unrolled into a single cycle
	function automatic logic [BYTE_W-1:0] crc8_byte(
		input logic [BYTE_W-1:0] crc,
		input logic [BYTE_W-1:0] data
	);
		logic [BYTE_W-1:0] c;
		logic              fb;
		c = crc;
		for (int i = BYTE_W - 1; i >= 0; i--) begin
			// Feedback is top CRC bit against incoming data bit
			fb = c[BYTE_W-1] ^ data[i];
			c  = {c[BYTE_W-2:0], 1'b0};
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

	assign crc_upd = crc8_byte(crc_q, pop_data_i);

	// Never stalls, drain whenever something is there
	assign pop_o = !empty_i;

	////////////////////////////////////////////////////////////////////////////
	// Compare and handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			crc_q     <= '0;
			ack_o     <= 1'b0;
			crc_err_o <= 1'b0;
		end else begin
			// Four-phase release, one cycle after req is seen low
			if (ack_o && !req_i)
				ack_o <= 1'b0;
			if (pop_o) begin
				if (pop_kind_i == KIND_CRC) begin
					// Stored CRC byte closes the packet
					crc_err_o <= (crc_q != pop_data_i);
					ack_o     <= 1'b1;
					crc_q     <= '0;
				end else begin
					crc_q <= crc_upd;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/pkt_check_top.sv
`default_nettype none

module pkt_check_top (
	input  logic                              clk,
	input  logic                              reset,
	// Four-phase request and acknowledge
	input  logic                              req_i,
	input  logic [pkt_check_pkg::ADDR_W-1:0]  hdr_addr_i,
	output logic                              ack_o,
	// Packet memory read port
	output logic                              mem_rd_o,
	output logic [pkt_check_pkg::ADDR_W-1:0]  mem_addr_o,
	input  logic [pkt_check_pkg::WORD_W-1:0]  mem_data_i,
	// Results, valid while ack is high
	output logic                              ecc_corr_o,
	output logic                              ecc_uncorr_o,
	output logic                              crc_err_o,
	output logic [pkt_check_pkg::CNT_W-1:0]   pkt_type_o,
	output logic [pkt_check_pkg::CNT_W-1:0]   byte_cnt_o
);
	import pkt_check_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Reader to FIFO
	////////////////////////////////////////////////////////////////////////////

	logic              push;
	logic [BYTE_W-1:0] push_data;
	byte_kind_t        push_kind;
	logic              full;

	////////////////////////////////////////////////////////////////////////////
	// FIFO to CRC stage
	////////////////////////////////////////////////////////////////////////////

	logic              pop;
	logic [BYTE_W-1:0] pop_data;
	byte_kind_t        pop_kind;
	logic              empty;

	// Header fetch, ECC check and byte stream
	hdr_reader hdr_reader_i (
		.clk          (clk),
		.reset        (reset),
		.req_i        (req_i),
		.hdr_addr_i   (hdr_addr_i),
		.mem_rd_o     (mem_rd_o),
		.mem_addr_o   (mem_addr_o),
		.mem_data_i   (mem_data_i),
		.push_o       (push),
		.push_data_o  (push_data),
		.push_kind_o  (push_kind),
		.full_i       (full),
		.ecc_corr_o   (ecc_corr_o),
		.ecc_uncorr_o (ecc_uncorr_o),
		.pkt_type_o   (pkt_type_o),
		.byte_cnt_o   (byte_cnt_o)
	);

	// Decouples memory reads from the CRC stage
	byte_fifo byte_fifo_i (
		.clk         (clk),
		.reset       (reset),
		.push_i      (push),
		.pop_i       (pop),
		.push_data_i (push_data),
		.push_kind_i (push_kind),
		.pop_data_o  (pop_data),
		.pop_kind_o  (pop_kind),
		.full_o      (full),
		.empty_o     (empty)
	);

	// CRC compare and ack generation
	crc_checker crc_checker_i (
		.clk        (clk),
		.reset      (reset),
		.req_i      (req_i),
		.pop_o      (pop),
		.pop_data_i (pop_data),
		.pop_kind_i (pop_kind),
		.empty_i    (empty),
		.ack_o      (ack_o),
		.crc_err_o  (crc_err_o)
	);

endmodule

`default_nettype wire

// File: test/pkt_check_checker.sv
`default_nettype none

module pkt_check_checker (
	input logic                             clk,
	input logic                             reset,
	input logic                             req_i,
	input logic                             ack_o,
	input logic                             mem_rd_o,
	input logic                             ecc_corr_o,
	input logic                             ecc_uncorr_o,
	input logic                             crc_err_o,
	input logic [pkt_check_pkg::CNT_W-1:0]  pkt_type_o,
	input logic [pkt_check_pkg::CNT_W-1:0]  byte_cnt_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertions, read by the testbench at the end of the run
	int unsigned fail_count = 0;

	// Idle handshake stays idle until a request shows up
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		(!req_i && !ack_o) |=> !ack_o)
	else begin
		fail_count++;
		$error("ack_o rose while req_i was low");
	end

	// Results frozen for the whole acknowledge phase
	results_stable: assert property (@(posedge clk) disable iff (reset)
		(ack_o && $past(ack_o)) |->
		$stable({ecc_corr_o, ecc_uncorr_o, crc_err_o, pkt_type_o, byte_cnt_o}))
	else begin
		fail_count++;
		$error("Result outputs changed while ack_o was high");
	end

	// At most one read every two cycles
	single_read: assert property (@(posedge clk) disable iff (reset)
		mem_rd_o |=> !mem_rd_o)
	else begin
		fail_count++;
		$error("mem_rd_o was high in two consecutive cycles");
	end

endmodule

bind pkt_check_top pkt_check_checker pkt_check_checker_i (.*);

`default_nettype wire

// File: test/pkt_check_tb.sv
`default_nettype none

module pkt_check_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import pkt_check_pkg::*;

	localparam int CLK_PERIOD = 20;
	// Header corruption modes
	localparam int ECC_NONE  = 0;
	localparam int ECC_CODE1 = 1;
	localparam int ECC_DATA1 = 2;
	localparam int ECC_DATA2 = 3;

	logic              clk;
	logic              reset;
	logic              req;
	logic [ADDR_W-1:0] hdr_addr;
	logic              ack;
	logic              mem_rd;
	logic [ADDR_W-1:0] mem_addr;
	logic [WORD_W-1:0] mem_data;
	logic              ecc_corr;
	logic              ecc_uncorr;
	logic              crc_err;
	logic [CNT_W-1:0]  pkt_type;
	logic [CNT_W-1:0]  byte_cnt;

	// Packet memory
	logic [WORD_W-1:0] mem [2**ADDR_W];

	// One stimulus table row per request
	int tab_addr[$];
	int tab_type[$];
	int tab_cnt[$];
	int tab_ecc[$];
	int tab_crc_bad[$];

	int n_checks;
	int n_errors;

	pkt_check_top pkt_check_top_i (
		.clk          (clk),
		.reset        (reset),
		.req_i        (req),
		.hdr_addr_i   (hdr_addr),
		.ack_o        (ack),
		.mem_rd_o     (mem_rd),
		.mem_addr_o   (mem_addr),
		.mem_data_i   (mem_data),
		.ecc_corr_o   (ecc_corr),
		.ecc_uncorr_o (ecc_uncorr),
		.crc_err_o    (crc_err),
		.pkt_type_o   (pkt_type),
		.byte_cnt_o   (byte_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Read port returns data one cycle after the strobe
	always @(posedge clk) begin
		if (mem_rd)
			mem_data <= mem[mem_addr];
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Each code bit is the parity of a mask over {type, count}
	function automatic logic [3:0] code_of(input logic [7:0] d);
		logic [3:0] c;
		c[0] = ^(d & 8'h5B);
		c[1] = ^(d & 8'h6D);
		c[2] = ^(d & 8'h8E);
		c[3] = ^(d & 8'hF0);
		return c;
	endfunction

	// CRC-8 byte step with the byte folded into the top and shifted out
	function automatic logic [7:0] crc_next(input logic [7:0] crc, input logic [7:0] b);
		logic [7:0] r;
		r = crc ^ b;
		for (int n = 0; n < 8; n++)
			r = r[7] ? ((r << 1) ^ CRC_POLY) : (r << 1);
		return r;
	endfunction

	task automatic add_entry(input int addr, input int typ, input int cnt, input int ecc,
			input int crc_bad);
		tab_addr.push_back(addr);
		tab_type.push_back(typ);
		tab_cnt.push_back(cnt);
		tab_ecc.push_back(ecc);
		tab_crc_bad.push_back(crc_bad);
	endtask

	// Writes header, payload and CRC word and returns the expected results
	task automatic load_packet(input int idx, output logic exp_corr, output logic exp_uncorr,
			output logic exp_crc_err, output logic [3:0] exp_type);
		logic [ADDR_W-1:0] base;
		logic [WORD_W-1:0] hdr;
		logic [WORD_W-1:0] word;
		logic [7:0]        d;
		logic [7:0]        rx;
		logic [3:0]        syn;
		logic [7:0]        crc;
		int                flip;
		base = ADDR_W'(tab_addr[idx]);
		d    = {4'(tab_type[idx]), 4'(tab_cnt[idx])};
		// Upper bits including SOP are random
		hdr        = $urandom;
		hdr[3:0]   = code_of(d);
		hdr[7:4]   = d[3:0];
		hdr[11:8]  = d[7:4];
		hdr[12]    = ^d;
		crc = '0;
		for (int k = 0; k < tab_cnt[idx]; k++) begin
			word = $urandom;
			mem[base + 1 + k] = word;
			crc = crc_next(crc, word[7:0]);
		end
		word = $urandom;
		word[7:0] = crc;
		if (tab_crc_bad[idx] != 0)
			word[7:0] = crc ^ 8'(1 << ($urandom % 8));
		mem[base + 1 + tab_cnt[idx]] = word;
		exp_crc_err = (word[7:0] != crc);
		// Flips stay out of the count field so the read length holds
		flip = $urandom % 4;
		case (tab_ecc[idx])
			ECC_CODE1: hdr[ECC_LSB + flip] = ~hdr[ECC_LSB + flip];
			ECC_DATA1: hdr[TYPE_LSB + flip] = ~hdr[TYPE_LSB + flip];
			ECC_DATA2: begin
				hdr[TYPE_LSB + flip] = ~hdr[TYPE_LSB + flip];
				flip = (flip + 1 + $urandom % 3) % 4;
				hdr[TYPE_LSB + flip] = ~hdr[TYPE_LSB + flip];
			end
			default: ;
		endcase
		mem[base] = hdr;
		// Parity covers only d and a lone code bit flip decodes as uncorrectable
		rx         = {hdr[11:8], hdr[7:4]};
		syn        = hdr[3:0] ^ code_of(rx);
		exp_corr   = (syn != 0) && (hdr[12] != ^rx);
		exp_uncorr = (syn != 0) && (hdr[12] == ^rx);
		exp_type   = hdr[11:8];
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		n_checks++;
		assert (got == exp)
		else begin
			n_errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $realtime, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic       exp_corr;
		logic       exp_uncorr;
		logic       exp_crc_err;
		logic [3:0] exp_type;
		int         cycles;
		int         min_cycles;
		$timeformat(-9, 1, " ns", 0);
		void'($urandom(53));
		reset    = 1'b1;
		req      = 1'b0;
		hdr_addr = '0;
		mem_data = '0;
		n_checks = 0;
		n_errors = 0;
		for (int a = 0; a < 2**ADDR_W; a++)
			mem[a] = {a[15:0], ~a[15:0]};
		// Address, type, count, ECC mode, bad CRC
		add_entry('h0010,  3,  0, ECC_NONE,  0);
		add_entry('h0100,  5,  5, ECC_NONE,  0);
		add_entry('h0200, 10, 15, ECC_NONE,  0);
		add_entry('h0300,  7,  4, ECC_NONE,  1);
		add_entry('h0400,  6,  6, ECC_DATA1, 0);
		add_entry('h0500,  9,  3, ECC_DATA2, 0);
		add_entry('h0600, 12,  2, ECC_CODE1, 0);
		add_entry('h3FF0, 15,  8, ECC_DATA1, 1);
		add_entry('h0020,  0,  0, ECC_NONE,  0);
		// Overlaps the packet before
		add_entry('h0021,  4,  1, ECC_NONE,  0);
		repeat (2) @(posedge clk);
		#2 reset = 1'b0;
		for (int i = 0; i < tab_addr.size(); i++) begin
			load_packet(i, exp_corr, exp_uncorr, exp_crc_err, exp_type);
			hdr_addr = ADDR_W'(tab_addr[i]);
			req      = 1'b1;
			cycles   = 0;
			while (!ack) begin
				@(posedge clk);
				#2;
				cycles++;
			end
			min_cycles = 2 * (tab_cnt[i] + 2) + 2;
			n_checks++;
			assert (cycles >= min_cycles)
			else begin
				n_errors++;
				$display("Error at %0t: ack_o after %0d cycles, expected at least %0d",
					$realtime, cycles, min_cycles);
			end
			check_value("ecc_corr_o", ecc_corr, exp_corr);
			check_value("ecc_uncorr_o", ecc_uncorr, exp_uncorr);
			check_value("crc_err_o", crc_err, exp_crc_err);
			check_value("pkt_type_o", pkt_type, exp_type);
			check_value("byte_cnt_o", byte_cnt, tab_cnt[i]);
			// Requester keeps req high a few cycles while the results must hold
			repeat (1 + $urandom % 3) begin
				@(posedge clk);
				#2;
			end
			// Ack drops one cycle after the release
			req = 1'b0;
			@(posedge clk);
			#2;
			check_value("ack_o after release", ack, 0);
			// Every other request starts after an idle cycle with req and ack low
			if (i % 2 == 1) begin
				@(posedge clk);
				#2;
			end
		end
		$display("Checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors,
			pkt_check_top_i.pkt_check_checker_i.fail_count);
		if (n_errors == 0 && pkt_check_top_i.pkt_check_checker_i.fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		@(negedge reset);
		repeat (tab_addr.size() * 60 + 100) @(posedge clk);
		$display("Timeout: the DUT did not complete the requests, errors so far: %0d",
			n_errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
hdl/pkt_check_pkg.sv
hdl/hdr_reader.sv
hdl/byte_fifo.sv
hdl/crc_checker.sv
hdl/pkt_check_top.sv
test/pkt_check_checker.sv
test/pkt_check_tb.sv

// File: Bender.yml
package:
  name: pkt_check

sources:
  - files:
      - hdl/pkt_check_pkg.sv
      - hdl/hdr_reader.sv
      - hdl/byte_fifo.sv
      - hdl/crc_checker.sv
      - hdl/pkt_check_top.sv
  - target: test
    files:
      - test/pkt_check_checker.sv
      - test/pkt_check_tb.sv
